/* verification/exe_cases.txt */
# kind op_a op_b alu_fn wb_sel pc imm ctrl trap mode exp exp2 (all hex)
# kind 0 writeback, 1 branch or jump, 2 sync trap, 3 interrupt (ctrl holds the interrupt inputs)
0 00000005 00000007 0 0 00000000 00000000 000 00 3 0000000c 0
0 00000005 00000007 8 0 00000000 00000000 000 00 3 fffffffe 0
0 00000001 00000024 1 0 00000000 00000000 000 00 3 00000010 0
0 ffffffff 00000001 2 0 00000000 00000000 000 00 3 00000001 0
0 ffffffff 00000001 3 0 00000000 00000000 000 00 3 00000000 0
0 f0f0f0f0 0ff00ff0 4 0 00000000 00000000 000 00 3 ff00ff00 0
0 80000000 00000004 5 0 00000000 00000000 000 00 3 08000000 0
0 80000000 00000004 d 0 00000000 00000000 000 00 3 f8000000 0
0 12340000 00005678 6 0 00000000 00000000 000 00 3 12345678 0
0 ff00ff00 0ff00ff0 7 0 00000000 00000000 000 00 3 0f000f00 0
0 00000005 00000007 9 0 00000000 00000000 000 00 3 00000000 0
0 00000000 00000000 0 1 00001000 00000000 000 00 3 00001004 0
0 00000000 00000000 0 3 00001000 12345000 000 00 3 12345000 0
0 00000000 00000000 0 5 00001000 00002000 000 00 3 00003000 0
1 00000009 00000009 8 0 00000100 00000040 018 00 3 00000140 1
1 00000009 00000008 8 0 00000100 00000040 018 00 3 00000140 0
1 00000009 00000008 8 0 00000200 fffffff0 01c 00 3 000001f0 1
1 ffffffff 00000001 2 0 00000300 00000020 01c 00 3 00000320 1
1 00000005 00000003 2 0 00000300 00000020 01c 00 3 00000320 0
1 00000000 00000000 0 0 00000400 00000800 012 00 3 00000c00 1
1 00001001 00000004 0 0 00000500 00000040 031 00 3 00001004 3
2 00000000 00000000 0 0 00000600 00000000 000 40 0 00000008 0
2 00000000 00000000 0 0 00000604 00000000 000 40 1 00000009 0
2 00000000 00000000 0 0 00000608 00000000 000 40 3 0000000b 0
2 00000000 00000000 0 0 0000060c 00000000 000 20 3 00000003 0
2 00000000 00000000 0 0 00000610 00000000 000 10 3 00000002 0
2 00000000 00000000 0 0 00000614 00000000 000 90 3 00000000 0
2 00000000 00000000 0 0 00000618 00000000 000 04 3 00000000 0
3 00000000 00000000 0 0 00000000 00000000 238 00 0 8000000b 7
3 00000000 00000000 0 0 00000000 00000000 230 00 3 00000000 0
3 00000000 00000000 0 0 00000000 00000000 230 00 1 80000009 2
3 00000000 00000000 0 0 00000000 00000000 261 00 0 80000007 1
3 00000000 00000000 0 0 00000000 00000000 186 00 0 80000005 0
3 00000000 00000000 0 0 00000000 00000000 104 00 0 80000004 0
3 00000000 00000000 0 0 00000000 00000000 104 00 1 00000000 0

/* filelist.f */
hdl/exe_pkg.sv
hdl/exe_if.sv
hdl/exe_issue_latch.sv
hdl/exe_alu_branch.sv
hdl/exe_commit_latch.sv
hdl/exe_trap_unit.sv
hdl/exe_top.sv
verification/exe_asserts.sv
verification/tb_exe.sv

/* Bender.yml */
package:
  name: exe_stage

sources:
  - hdl/exe_pkg.sv
  - hdl/exe_if.sv
  - hdl/exe_issue_latch.sv
  - hdl/exe_alu_branch.sv
  - hdl/exe_commit_latch.sv
  - hdl/exe_trap_unit.sv
  - hdl/exe_top.sv
  - target: simulation
    files:
      - verification/exe_asserts.sv
      - verification/tb_exe.sv

/* verification/tb_exe.sv */
`timescale 1ns/10ps

module tb_exe;
	import exe_pkg::*;

	typedef struct packed {
		logic [3:0] kind;
		word_t op_a;
		word_t op_b;
		alu_fn_t alu_fn;
		wb_sel_t wb_sel;
		word_t pc;
		word_t imm;
		logic [9:0] ctrl;
		logic [7:0] trap;
		priv_t mode;
		word_t exp;
		logic [31:0] exp2;
	} case_t;

	logic clk = 1'b0;
	logic nrst;
	word_t op_a, op_b, pc4, b_imm4, j_imm4, u_imm4;
	alu_fn_t alu_fn4;
	wb_sel_t wb_sel4;
	reg_addr_t rd4;
	logic we4, btype4, bneq4, j4, jr4;
	pc_sel_t pcselect4;
	logic instr_misaligned4, ecall4, ebreak4, illegal_instr4, illegal_ret4;
	logic mret4, sret4, uret4;
	priv_t current_mode;
	logic m_tie, s_tie, u_tie, m_eie, s_eie, u_eie;
	logic m_timer, s_timer, u_timer, external_interrupt;
	word_t target, wb_data6, pc6, u_imm6, au_imm6;
	pc_sel_t pcselect5;
	reg_addr_t rd6;
	logic we6, mret6, sret6, uret6;
	logic m_interrupt, s_interrupt, u_interrupt, exception_pending;
	cause_t cause6;

	case_t cases[$];
	int cycles = 0;
	int limit = 50; // raised once the cases are read
	logic [31:0] lcg_state = 32'd6754;

	exe_top #(.link_offset(32'd4)) exe_top_inst (.*);

	bind exe_top exe_asserts asserts_inst (.*);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			stop_run();
		end
	end

	task automatic stop_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
		begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_cause(input string name, input cause_t exp, input cause_t act);
		if (act !== exp)
		begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_pc_sel(input string name, input pc_sel_t exp, input pc_sel_t act);
		if (act !== exp)
		begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic idle_instr();
		op_a <= '0;
		op_b <= '0;
		{pc4, b_imm4, j_imm4, u_imm4} <= '0;
		alu_fn4 <= alu_add;
		wb_sel4 <= wb_alu;
		rd4 <= '0;
		{we4, btype4, bneq4, j4, jr4} <= '0;
		pcselect4 <= pc_seq;
		{instr_misaligned4, ecall4, ebreak4, illegal_instr4} <= '0;
		{illegal_ret4, mret4, sret4, uret4} <= '0;
	endtask

	task automatic clear_intr();
		{m_tie, s_tie, u_tie, m_eie, s_eie, u_eie} <= '0;
		{m_timer, s_timer, u_timer, external_interrupt} <= '0;
	endtask

	task automatic drive_instr(input case_t c, input reg_addr_t rd, input logic we);
		op_a <= c.op_a;
		op_b <= c.op_b;
		pc4 <= c.pc;
		b_imm4 <= c.imm; // one immediate column feeds all three
		j_imm4 <= c.imm;
		u_imm4 <= c.imm;
		alu_fn4 <= c.alu_fn;
		wb_sel4 <= c.wb_sel;
		rd4 <= rd;
		we4 <= we;
		pcselect4 <= c.ctrl[5:4];
		{btype4, bneq4, j4, jr4} <= c.ctrl[3:0];
		{instr_misaligned4, ecall4, ebreak4, illegal_instr4} <= c.trap[7:4];
		{illegal_ret4, mret4, sret4, uret4} <= c.trap[3:0];
		current_mode <= c.mode;
	endtask

	task automatic drive_intr(input case_t c);
		current_mode <= c.mode;
		{external_interrupt, u_timer, s_timer, m_timer} <= c.ctrl[9:6];
		{u_eie, s_eie, m_eie, u_tie, s_tie, m_tie} <= c.ctrl[5:0];
	endtask

	task automatic read_cases();
		int fd;
		int n;
		string line;
		logic [31:0] k, a, b, fn, ws, p, im, ct, tr, md, e1, e2;
		case_t c;
		fd = $fopen("verification/exe_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the case file");
			stop_run();
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
				k, a, b, fn, ws, p, im, ct, tr, md, e1, e2);
			if (n == 12) // header and blank lines fall through
			begin
				c = {k[3:0], a, b, fn[3:0], ws[2:0], p, im, ct[9:0], tr[7:0], md[1:0], e1, e2};
				cases.push_back(c);
			end
		end
		$fclose(fd);
		if (cases.size() == 0)
		begin
			$display("The case file holds no test cases");
			stop_run();
		end
		limit = 8 * cases.size() + 50;
	endtask

	task automatic run_case(input case_t c);
		logic [31:0] r;
		reg_addr_t rd;
		logic we;
		case_t f;
		r = next_rand();
		rd = r[20:16];
		we = r[21];
		f = '0;
		f.op_a = 32'h11;
		f.pc = c.pc + 32'd4;
		f.mode = c.mode;
		case (c.kind)
			4'd0:
			begin
				@(posedge clk) drive_instr(c, rd, we);
				@(posedge clk) idle_instr();
				@(posedge clk);
				@(negedge clk);
				check_word("wb_data6", c.exp, wb_data6);
				check_word("rd6", {27'd0, rd}, {27'd0, rd6});
				check_bit("we6", we, we6);
				check_word("pc6", c.pc, pc6);
				check_word("u_imm6", c.imm, u_imm6);
				if (c.wb_sel == wb_auipc)
					check_word("au_imm6", c.exp, au_imm6);
			end
			4'd1:
			begin
				@(posedge clk) drive_instr(c, rd, we);
				@(posedge clk) idle_instr();
				@(negedge clk);
				check_word("target", c.exp, target);
				check_pc_sel("pcselect5", c.exp2[1:0], pcselect5);
			end
			4'd2:
			begin
				@(posedge clk) drive_instr(c, rd, we);
				@(posedge clk) drive_instr(f, rd, 1'b1); // follower gets flushed
				@(posedge clk) idle_instr();
				@(negedge clk);
				check_bit("exception_pending", 1'b1, exception_pending);
				check_cause("cause6", c.exp, cause6);
				check_word("pc6", c.pc, pc6);
				check_bit("mret6", c.trap[2], mret6);
				check_bit("sret6", c.trap[1], sret6);
				check_bit("uret6", c.trap[0], uret6);
				@(negedge clk);
				check_bit("we6", 1'b0, we6);
				check_bit("exception_pending", 1'b0, exception_pending);
				check_word("pc6", f.pc, pc6); // pc survives the flush
			end
			4'd3:
			begin
				@(posedge clk) drive_intr(c);
				@(negedge clk);
				check_bit("m_interrupt", c.exp2[2], m_interrupt);
				check_bit("s_interrupt", c.exp2[1], s_interrupt);
				check_bit("u_interrupt", c.exp2[0], u_interrupt);
				check_cause("cause6", c.exp, cause6);
				check_bit("exception_pending", c.exp[31], exception_pending);
				@(posedge clk) clear_intr();
			end
			default:
			begin
				$display("Unknown case kind %0d in the case file", c.kind);
				stop_run();
			end
		endcase
	endtask

	initial
	begin
		nrst <= 1'b0;
		current_mode <= priv_m;
		idle_instr();
		clear_intr();
		read_cases();
		repeat (8) @(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		check_bit("we6", 1'b0, we6); // state right after reset
		check_bit("exception_pending", 1'b0, exception_pending);
		check_pc_sel("pcselect5", pc_seq, pcselect5);
		foreach (cases[i])
			run_case(cases[i]);
		@(posedge clk);
		@(negedge clk);
		if (exe_top_inst.asserts_inst.fail_count == 0)
		begin
			$display("Testbench passed");
			$finish;
		end
		else
		begin
			$display("%0d assertion failures", exe_top_inst.asserts_inst.fail_count);
			stop_run();
		end
	end

endmodule

/* verification/exe_asserts.sv */
`timescale 1ns/10ps

module exe_asserts (
	input logic clk,
	input logic nrst,
	input logic exception_pending,
	input logic we6,
	input logic btype4,
	input logic j4,
	input logic jr4,
	input logic m_timer,
	input logic s_timer,
	input logic u_timer,
	input logic external_interrupt,
	input exe_pkg::pc_sel_t pcselect5
);
	import exe_pkg::*;

	int fail_count = 0;
	logic intr_in;

	assign intr_in = m_timer || s_timer || u_timer || external_interrupt;

	// a sync trap flushes its own flags
	pending_one_cycle: assert property (@(posedge clk) disable iff (!nrst)
		(exception_pending && !intr_in) |=> (!exception_pending || intr_in))
		else begin fail_count++; $error("exception_pending held without interrupt"); end

	flush_clears_we: assert property (@(posedge clk) disable iff (!nrst)
		(exception_pending && !intr_in) |=> !we6)
		else begin fail_count++; $error("we6 set after a synchronous trap"); end

	no_redirect: assert property (@(posedge clk) disable iff (!nrst)
		!(btype4 || j4 || jr4) |=> (pcselect5 == pc_seq))
		else begin fail_count++; $error("pcselect5 redirect without branch or jump"); end

endmodule

/* hdl/exe_top.sv */
`timescale 1ns/10ps

module exe_top #(
	parameter exe_pkg::word_t link_offset = 32'd4
) (
	input logic clk,
	input logic nrst,
	input exe_pkg::word_t op_a,
	input exe_pkg::word_t op_b,
	input exe_pkg::word_t pc4,
	input exe_pkg::word_t b_imm4,
	input exe_pkg::word_t j_imm4,
	input exe_pkg::word_t u_imm4,
	input exe_pkg::alu_fn_t alu_fn4,
	input exe_pkg::wb_sel_t wb_sel4,
	input exe_pkg::reg_addr_t rd4,
	input logic we4,
	input logic btype4,
	input logic bneq4,
	input logic j4,
	input logic jr4,
	input exe_pkg::pc_sel_t pcselect4,
	input logic instr_misaligned4,
	input logic ecall4,
	input logic ebreak4,
	input logic illegal_instr4,
	input logic illegal_ret4,
	input logic mret4,
	input logic sret4,
	input logic uret4,
	input exe_pkg::priv_t current_mode,
	input logic m_tie,
	input logic s_tie,
	input logic u_tie,
	input logic m_eie,
	input logic s_eie,
	input logic u_eie,
	input logic m_timer,
	input logic s_timer,
	input logic u_timer,
	input logic external_interrupt,
	output exe_pkg::word_t target,
	output exe_pkg::pc_sel_t pcselect5,
	output exe_pkg::word_t wb_data6,
	output exe_pkg::word_t pc6,
	output exe_pkg::word_t u_imm6,
	output exe_pkg::word_t au_imm6,
	output exe_pkg::reg_addr_t rd6,
	output logic we6,
	output logic mret6,
	output logic sret6,
	output logic uret6,
	output logic m_interrupt,
	output logic s_interrupt,
	output logic u_interrupt,
	output exe_pkg::cause_t cause6,
	output logic exception_pending
);
	import exe_pkg::*;

	word_t alu_res5;

	exe_stage5_if s5_if ();
	exe_trap_if trap_if ();

	// exception_pending doubles as the flush for both stages
	exe_issue_latch issue_inst (
		.clk(clk), .nrst(nrst), .exception(exception_pending),
		.op_a(op_a), .op_b(op_b), .pc4(pc4),
		.b_imm4(b_imm4), .j_imm4(j_imm4), .u_imm4(u_imm4),
		.alu_fn4(alu_fn4), .wb_sel4(wb_sel4), .rd4(rd4), .we4(we4),
		.btype4(btype4), .bneq4(bneq4), .j4(j4), .jr4(jr4), .pcselect4(pcselect4),
		.instr_misaligned4(instr_misaligned4), .ecall4(ecall4), .ebreak4(ebreak4),
		.illegal_instr4(illegal_instr4), .illegal_ret4(illegal_ret4),
		.mret4(mret4), .sret4(sret4), .uret4(uret4),
		.s5(s5_if.latch)
	);

	exe_alu_branch alu_inst (
		.s5(s5_if.compute),
		.alu_res5(alu_res5),
		.target(target),
		.pcselect5(pcselect5)
	);

	exe_commit_latch #(
		.link_offset(link_offset)
	) commit_inst (
		.clk(clk), .nrst(nrst), .exception(exception_pending),
		.s5(s5_if.commit), .alu_res5(alu_res5), .trap(trap_if.source),
		.wb_data6(wb_data6), .pc6(pc6), .u_imm6(u_imm6), .au_imm6(au_imm6),
		.rd6(rd6), .we6(we6), .mret6(mret6), .sret6(sret6), .uret6(uret6)
	);

	exe_trap_unit trap_inst (
		.trap(trap_if.sink), .current_mode(current_mode),
		.m_tie(m_tie), .s_tie(s_tie), .u_tie(u_tie),
		.m_eie(m_eie), .s_eie(s_eie), .u_eie(u_eie),
		.m_timer(m_timer), .s_timer(s_timer), .u_timer(u_timer),
		.external_interrupt(external_interrupt),
		.exception(exception_pending),
		.m_interrupt(m_interrupt), .s_interrupt(s_interrupt), .u_interrupt(u_interrupt),
		.cause6(cause6)
	);

endmodule

/* hdl/exe_trap_unit.sv */
`timescale 1ns/10ps

module exe_trap_unit (
	exe_trap_if.sink trap,
	input exe_pkg::priv_t current_mode,
	input logic m_tie,
	input logic s_tie,
	input logic u_tie,
	input logic m_eie,
	input logic s_eie,
	input logic u_eie,
	input logic m_timer,
	input logic s_timer,
	input logic u_timer,
	input logic external_interrupt,
	output logic exception,
	output logic m_interrupt,
	output logic s_interrupt,
	output logic u_interrupt,
	output exe_pkg::cause_t cause6
);
	import exe_pkg::*;

	logic m_timer_c, s_timer_c, u_timer_c;
	logic below_m, in_u;
	logic sync_trap;
	logic is_intr;
	logic [xlen-2:0] code;

	assign below_m = (current_mode != priv_m);
	assign in_u = (current_mode == priv_u);

	// m level needs only its enable
	assign m_timer_c = m_tie && m_timer;
	assign s_timer_c = below_m && s_tie && s_timer;
	assign u_timer_c = in_u && u_tie && u_timer;
	assign m_interrupt = m_eie && external_interrupt;
	assign s_interrupt = below_m && s_eie && external_interrupt;
	assign u_interrupt = in_u && u_eie && external_interrupt;

	// rets also flush the pipe
	assign sync_trap = trap.instr_misaligned || trap.ecall || trap.ebreak
		|| trap.illegal_instr || trap.illegal_ret || trap.mret || trap.sret || trap.uret;

	assign exception = sync_trap || m_timer_c || s_timer_c || u_timer_c
		|| m_interrupt || s_interrupt || u_interrupt;

	always_comb
	begin
		is_intr = 1'b1;
		code = '0;
		if (m_interrupt)
			code = cause_m_ext;
		else if (s_interrupt)
			code = cause_s_ext;
		else if (m_timer_c)
			code = cause_m_timer;
		else if (s_timer_c)
			code = cause_s_timer;
		else if (u_interrupt)
			code = cause_u_ext;
		else if (u_timer_c)
			code = cause_u_timer;
		else
		begin
			is_intr = 1'b0;
			if (trap.instr_misaligned)
				code = cause_i_misaligned;
			else if (trap.illegal_instr || trap.illegal_ret)
				code = cause_illegal;
			else if (trap.ecall)
			begin
				if (current_mode == priv_u)
					code = cause_u_call;
				else if (current_mode == priv_s)
					code = cause_s_call;
				else
					code = cause_m_call; // reserved mode lands here too
			end
			else if (trap.ebreak)
				code = cause_breakpoint;
		end
	end

	assign cause6 = {is_intr, code};

endmodule

/* hdl/exe_commit_latch.sv */
`timescale 1ns/10ps

module exe_commit_latch #(
	parameter exe_pkg::word_t link_offset = 32'd4
) (
	input logic clk,
	input logic nrst,
	input logic exception,
	exe_stage5_if.commit s5,
	input exe_pkg::word_t alu_res5,
	exe_trap_if.source trap,
	output exe_pkg::word_t wb_data6,
	output exe_pkg::word_t pc6,
	output exe_pkg::word_t u_imm6,
	output exe_pkg::word_t au_imm6,
	output exe_pkg::reg_addr_t rd6,
	output logic we6,
	output logic mret6,
	output logic sret6,
	output logic uret6
);
	import exe_pkg::*;

	word_t alu_res6;
	wb_sel_t wb_sel6;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			alu_res6 <= '0;
			wb_sel6 <= wb_alu;
			rd6 <= '0;
			we6 <= 1'b0;
			u_imm6 <= '0;
			au_imm6 <= '0;
			trap.pc <= '0;
			{trap.instr_misaligned, trap.ecall, trap.ebreak, trap.illegal_instr} <= '0;
			{trap.illegal_ret, trap.mret, trap.sret, trap.uret} <= '0;
		end
		else if (exception)
		begin
			alu_res6 <= '0;
			wb_sel6 <= wb_alu;
			rd6 <= '0;
			we6 <= 1'b0;
			u_imm6 <= '0;
			au_imm6 <= '0;
			trap.pc <= s5.pc; // kept for the trap handler
			{trap.instr_misaligned, trap.ecall, trap.ebreak, trap.illegal_instr} <= '0;
			{trap.illegal_ret, trap.mret, trap.sret, trap.uret} <= '0;
		end
		else
		begin
			alu_res6 <= alu_res5;
			wb_sel6 <= s5.wb_sel;
			rd6 <= s5.rd;
			we6 <= s5.we;
			u_imm6 <= s5.u_imm;
			au_imm6 <= s5.pc + s5.u_imm; // auipc sum
			trap.pc <= s5.pc;
			trap.instr_misaligned <= s5.instr_misaligned;
			trap.ecall <= s5.ecall;
			trap.ebreak <= s5.ebreak;
			trap.illegal_instr <= s5.illegal_instr;
			trap.illegal_ret <= s5.illegal_ret;
			trap.mret <= s5.mret;
			trap.sret <= s5.sret;
			trap.uret <= s5.uret;
		end
	end

	assign pc6 = trap.pc;
	assign mret6 = trap.mret;
	assign sret6 = trap.sret;
	assign uret6 = trap.uret;

	always_comb
	begin
		case (wb_sel6)
			wb_alu: wb_data6 = alu_res6;
			wb_link: wb_data6 = trap.pc + link_offset; // return address
			wb_lui: wb_data6 = u_imm6;
			wb_auipc: wb_data6 = au_imm6;
			default: wb_data6 = '0;
		endcase
	end

endmodule

/* hdl/exe_alu_branch.sv */
`timescale 1ns/10ps

module exe_alu_branch (
	exe_stage5_if.compute s5,
	output exe_pkg::word_t alu_res5,
	output exe_pkg::word_t target,
	output exe_pkg::pc_sel_t pcselect5
);
	import exe_pkg::*;

	logic btaken;
	logic res_zero;
	word_t jr_sum;

	always_comb
	begin
		case (s5.alu_fn)
			alu_add: alu_res5 = s5.op_a + s5.op_b;
			alu_sub: alu_res5 = s5.op_a - s5.op_b;
			alu_sll: alu_res5 = s5.op_a << s5.op_b[4:0];
			alu_srl: alu_res5 = s5.op_a >> s5.op_b[4:0];
			alu_sra: alu_res5 = word_t'($signed(s5.op_a) >>> s5.op_b[4:0]);
			alu_slt: alu_res5 = {31'd0, $signed(s5.op_a) < $signed(s5.op_b)};
			alu_sltu: alu_res5 = {31'd0, s5.op_a < s5.op_b};
			alu_xor: alu_res5 = s5.op_a ^ s5.op_b;
			alu_or: alu_res5 = s5.op_a | s5.op_b;
			alu_and: alu_res5 = s5.op_a & s5.op_b;
			default: alu_res5 = '0; // unused codes
		endcase
	end

	// beq uses sub with bneq clear, blt uses slt with bneq set
	assign res_zero = (alu_res5 == '0);
	assign btaken = s5.btype && (s5.bneq ? !res_zero : res_zero);

	assign jr_sum = s5.op_a + s5.op_b;

	always_comb
	begin
		if (s5.jr)
		begin
			target = {jr_sum[xlen-1:1], 1'b0}; // jalr drops bit 0
		end
		else if (s5.j)
		begin
			target = s5.pc + s5.j_imm;
		end
		else
		begin
			target = s5.pc + s5.b_imm;
		end
	end

	// redirect only on a taken branch or a jump
	assign pcselect5 = (btaken || s5.j || s5.jr) ? s5.pcselect : pc_seq;

endmodule

/* hdl/exe_issue_latch.sv */
`timescale 1ns/10ps

module exe_issue_latch (
	input logic clk,
	input logic nrst,
	input logic exception,
	input exe_pkg::word_t op_a,
	input exe_pkg::word_t op_b,
	input exe_pkg::word_t pc4,
	input exe_pkg::word_t b_imm4,
	input exe_pkg::word_t j_imm4,
	input exe_pkg::word_t u_imm4,
	input exe_pkg::alu_fn_t alu_fn4,
	input exe_pkg::wb_sel_t wb_sel4,
	input exe_pkg::reg_addr_t rd4,
	input logic we4,
	input logic btype4,
	input logic bneq4,
	input logic j4,
	input logic jr4,
	input exe_pkg::pc_sel_t pcselect4,
	input logic instr_misaligned4,
	input logic ecall4,
	input logic ebreak4,
	input logic illegal_instr4,
	input logic illegal_ret4,
	input logic mret4,
	input logic sret4,
	input logic uret4,
	exe_stage5_if.latch s5
);
	import exe_pkg::*;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			s5.op_a <= '0;
			s5.op_b <= '0;
			s5.pc <= '0;
			s5.b_imm <= '0;
			s5.j_imm <= '0;
			s5.u_imm <= '0;
			s5.alu_fn <= alu_add;
			s5.wb_sel <= wb_alu;
			s5.rd <= '0;
			s5.we <= 1'b0;
			s5.btype <= 1'b0;
			s5.bneq <= 1'b0;
			s5.j <= 1'b0;
			s5.jr <= 1'b0;
			s5.pcselect <= pc_seq;
			{s5.instr_misaligned, s5.ecall, s5.ebreak, s5.illegal_instr} <= '0;
			{s5.illegal_ret, s5.mret, s5.sret, s5.uret} <= '0;
		end
		else if (exception)
		begin
			// trap taken, squash whatever is being issued
			s5.op_a <= '0;
			s5.op_b <= '0;
			s5.pc <= '0;
			s5.b_imm <= '0;
			s5.j_imm <= '0;
			s5.u_imm <= '0;
			s5.alu_fn <= alu_add;
			s5.wb_sel <= wb_alu;
			s5.rd <= '0;
			s5.we <= 1'b0;
			s5.btype <= 1'b0;
			s5.bneq <= 1'b0;
			s5.j <= 1'b0;
			s5.jr <= 1'b0;
			s5.pcselect <= pc_seq;
			{s5.instr_misaligned, s5.ecall, s5.ebreak, s5.illegal_instr} <= '0;
			{s5.illegal_ret, s5.mret, s5.sret, s5.uret} <= '0;
		end
		else
		begin
			s5.op_a <= op_a;
			s5.op_b <= op_b;
			s5.pc <= pc4;
			s5.b_imm <= b_imm4;
			s5.j_imm <= j_imm4;
			s5.u_imm <= u_imm4;
			s5.alu_fn <= alu_fn4;
			s5.wb_sel <= wb_sel4;
			s5.rd <= rd4;
			s5.we <= we4;
			s5.btype <= btype4;
			s5.bneq <= bneq4;
			s5.j <= j4;
			s5.jr <= jr4;
			s5.pcselect <= pcselect4;
			s5.instr_misaligned <= instr_misaligned4;
			s5.ecall <= ecall4;
			s5.ebreak <= ebreak4;
			s5.illegal_instr <= illegal_instr4;
			s5.illegal_ret <= illegal_ret4;
			s5.mret <= mret4;
			s5.sret <= sret4;
			s5.uret <= uret4;
		end
	end

endmodule

/* hdl/exe_if.sv */
`timescale 1ns/10ps

// contents of the stage 5 register
interface exe_stage5_if;
	import exe_pkg::*;

	word_t op_a, op_b, pc;
	word_t b_imm, j_imm, u_imm;
	alu_fn_t alu_fn;
	wb_sel_t wb_sel;
	reg_addr_t rd;
	logic we, btype, bneq, j, jr;
	pc_sel_t pcselect;
	logic instr_misaligned, ecall, ebreak, illegal_instr, illegal_ret;
	logic mret, sret, uret;

	modport latch (output op_a, op_b, pc, b_imm, j_imm, u_imm, alu_fn, wb_sel, rd, we,
		btype, bneq, j, jr, pcselect, instr_misaligned, ecall, ebreak, illegal_instr,
		illegal_ret, mret, sret, uret);
	modport compute (input op_a, op_b, pc, b_imm, j_imm, alu_fn, btype, bneq, j, jr,
		pcselect);
	modport commit (input pc, u_imm, wb_sel, rd, we, instr_misaligned, ecall, ebreak,
		illegal_instr, illegal_ret, mret, sret, uret);
endinterface

// stage 6 trap flags and pc
interface exe_trap_if;
	import exe_pkg::*;

	word_t pc;
	logic instr_misaligned, ecall, ebreak, illegal_instr, illegal_ret;
	logic mret, sret, uret;

	modport source (output pc, instr_misaligned, ecall, ebreak, illegal_instr, illegal_ret,
		mret, sret, uret);
	modport sink (input pc, instr_misaligned, ecall, ebreak, illegal_instr, illegal_ret,
		mret, sret, uret);
endinterface

/* hdl/exe_pkg.sv */
package exe_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [3:0] alu_fn_t;
	typedef logic [2:0] wb_sel_t;
	typedef logic [1:0] pc_sel_t;
	typedef logic [1:0] priv_t;
	typedef logic [xlen-1:0] cause_t; // msb set for interrupts

	// alu codes, funct order
	localparam alu_fn_t alu_add  = 4'd0;
	localparam alu_fn_t alu_sll  = 4'd1;
	localparam alu_fn_t alu_slt  = 4'd2;
	localparam alu_fn_t alu_sltu = 4'd3;
	localparam alu_fn_t alu_xor  = 4'd4;
	localparam alu_fn_t alu_srl  = 4'd5;
	localparam alu_fn_t alu_or   = 4'd6;
	localparam alu_fn_t alu_and  = 4'd7;
	localparam alu_fn_t alu_sub  = 4'd8;
	localparam alu_fn_t alu_sra  = 4'd13;

	localparam wb_sel_t wb_alu   = 3'd0;
	localparam wb_sel_t wb_link  = 3'd1;
	localparam wb_sel_t wb_lui   = 3'd3;
	localparam wb_sel_t wb_auipc = 3'd5;

	localparam pc_sel_t pc_seq = 2'd0; // no redirect

	localparam priv_t priv_u = 2'd0;
	localparam priv_t priv_s = 2'd1;
	localparam priv_t priv_m = 2'd3;

	// synchronous causes
	localparam logic [xlen-2:0] cause_i_misaligned = 31'd0;
	localparam logic [xlen-2:0] cause_illegal      = 31'd2;
	localparam logic [xlen-2:0] cause_breakpoint   = 31'd3;
	localparam logic [xlen-2:0] cause_u_call       = 31'd8;
	localparam logic [xlen-2:0] cause_s_call       = 31'd9;
	localparam logic [xlen-2:0] cause_m_call       = 31'd11;

	// interrupt causes
	localparam logic [xlen-2:0] cause_u_timer = 31'd4;
	localparam logic [xlen-2:0] cause_s_timer = 31'd5;
	localparam logic [xlen-2:0] cause_m_timer = 31'd7;
	localparam logic [xlen-2:0] cause_u_ext   = 31'd8;
	localparam logic [xlen-2:0] cause_s_ext   = 31'd9;
	localparam logic [xlen-2:0] cause_m_ext   = 31'd11;

endpackage
